// File: Bender.yml
package:
  name: lc3b_pipeline

sources:
  - lc3b_pkg.sv
  - instruction_fetch.sv
  - instruction_decode.sv
  - execution_module.sv
  - memory_module.sv
  - cpu_datapath.sv
  - target: test
    files:
      - cpu_datapath_chk.sv
      - tb_cpu_datapath.sv

// File: cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath import lc3b_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lc3b_word mem_rdata1,
	input  lc3b_word mem_rdata2,
	output lc3b_word mem_address1,
	output logic     mem_read1,
	output lc3b_word mem_address2,
	output lc3b_word mem_wdata2,
	output logic     mem_read2,
	output logic     mem_write2
);

	lc3b_word if_ir, if_pc;                             // IF/ID
	lc3b_word id_ir, id_pc, id_sr1, id_sr2;             // ID/EX
	lc3b_cw   id_cw;
	lc3b_word ex_ir, ex_alu, ex_sr2;                    // EX/MEM
	lc3b_cw   ex_cw;
	logic     br_taken;                                 // EX back to IF/ID
	lc3b_word br_target;
	logic     wb_load;                                  // Register write port
	lc3b_reg  wb_dest;
	lc3b_word wb_data;
	lc3b_nzp  nzp;

	instruction_fetch if_logic (
		.clk          (clk),
		.rst          (rst),
		.br_taken     (br_taken),
		.br_target    (br_target),
		.mem_rdata1   (mem_rdata1),
		.mem_address1 (mem_address1),
		.mem_read1    (mem_read1),
		.if_ir        (if_ir),
		.if_pc        (if_pc)
	);

	instruction_decode id_logic (
		.clk      (clk),
		.rst      (rst),
		.br_taken (br_taken),
		.if_ir    (if_ir),
		.if_pc    (if_pc),
		.wb_load  (wb_load),
		.wb_dest  (wb_dest),
		.wb_data  (wb_data),
		.id_ir    (id_ir),
		.id_pc    (id_pc),
		.id_cw    (id_cw),
		.id_sr1   (id_sr1),
		.id_sr2   (id_sr2)
	);

	execution_module ex_module (
		.clk       (clk),
		.rst       (rst),
		.id_ir     (id_ir),
		.id_pc     (id_pc),
		.id_cw     (id_cw),
		.id_sr1    (id_sr1),
		.id_sr2    (id_sr2),
		.nzp       (nzp),
		.br_taken  (br_taken),
		.br_target (br_target),
		.ex_ir     (ex_ir),
		.ex_cw     (ex_cw),
		.ex_alu    (ex_alu),
		.ex_sr2    (ex_sr2)
	);

	memory_module mem_module (
		.clk          (clk),
		.rst          (rst),
		.ex_ir        (ex_ir),
		.ex_cw        (ex_cw),
		.ex_alu       (ex_alu),
		.ex_sr2       (ex_sr2),
		.mem_rdata2   (mem_rdata2),
		.mem_address2 (mem_address2),
		.mem_wdata2   (mem_wdata2),
		.mem_read2    (mem_read2),
		.mem_write2   (mem_write2),
		.wb_load      (wb_load),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.nzp          (nzp)
	);

endmodule : cpu_datapath

// File: cpu_datapath_chk.sv
`timescale 1ns/1ps

module cpu_datapath_chk (
	input logic clk,
	input logic rst,
	input logic mem_read1,
	input logic mem_read2,
	input logic mem_write2
);

	int unsigned fails = 0;  // Failure count for the end-of-run summary

	assert property (@(negedge clk) !(mem_read2 && mem_write2))
		else begin
			fails++;
			$error("data port read and write high in the same cycle");
		end

	// Pipeline holds only NOPs while in reset
	assert property (@(negedge clk) rst |-> (!mem_read2 && !mem_write2))
		else begin
			fails++;
			$error("data port strobe high during reset");
		end

	assert property (@(negedge clk) $fell(rst) |-> (!mem_read2 && !mem_write2))
		else begin
			fails++;
			$error("data port strobe high in the first cycle after reset");
		end

	assert property (@(negedge clk) !rst |-> mem_read1)
		else begin
			fails++;
			$error("instruction read low outside reset");
		end

endmodule : cpu_datapath_chk

// File: execution_module.sv
`timescale 1ns/1ps

module execution_module import lc3b_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lc3b_word id_ir,
	input  lc3b_word id_pc,
	input  lc3b_cw   id_cw,
	input  lc3b_word id_sr1,
	input  lc3b_word id_sr2,
	input  lc3b_nzp  nzp,
	output logic     br_taken,
	output lc3b_word br_target,
	output lc3b_word ex_ir,
	output lc3b_cw   ex_cw,
	output lc3b_word ex_alu,
	output lc3b_word ex_sr2
);

	lc3b_word imm5;
	lc3b_word off6;
	lc3b_word off9;
	lc3b_word alu_b;
	lc3b_word alu_out;
	alu_op_t  alu_op;

	assign imm5 = {{11{id_ir[4]}}, id_ir[4:0]};
	assign off6 = {{9{id_ir[5]}}, id_ir[5:0], 1'b0};  // Word offset to bytes
	assign off9 = {{6{id_ir[8]}}, id_ir[8:0], 1'b0};

	assign alu_op = alu_op_t'(id_cw[cw_alu_msb:cw_alu_lsb]);

	always_comb begin
		if (id_cw[cw_imm])
			alu_b = imm5;
		else if (id_cw[cw_mem_read] || id_cw[cw_mem_write])
			alu_b = off6;
		else
			alu_b = id_sr2;
	end

	always_comb begin
		case (alu_op)
			alu_add: alu_out = id_sr1 + alu_b;
			alu_and: alu_out = id_sr1 & alu_b;
			alu_not: alu_out = ~id_sr1;
			default: alu_out = alu_b;  // alu_pass
		endcase
	end

	// id_pc already points past the branch
	assign br_target = id_pc + off9;
	assign br_taken  = id_cw[cw_branch] & (|(id_ir[11:9] & nzp));

	// EX/MEM register
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_ir  <= nop_word;
			ex_cw  <= '0;
			ex_alu <= '0;
			ex_sr2 <= '0;
		end else begin
			ex_ir  <= id_ir;
			ex_cw  <= id_cw;
			ex_alu <= alu_out;
			ex_sr2 <= id_sr2;  // Store data for STR
		end
	end

endmodule : execution_module

// File: instruction_decode.sv
`timescale 1ns/1ps

module instruction_decode import lc3b_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     br_taken,
	input  lc3b_word if_ir,
	input  lc3b_word if_pc,
	input  logic     wb_load,
	input  lc3b_reg  wb_dest,
	input  lc3b_word wb_data,
	output lc3b_word id_ir,
	output lc3b_word id_pc,
	output lc3b_cw   id_cw,
	output lc3b_word id_sr1,
	output lc3b_word id_sr2
);

	lc3b_word   regs [8];
	lc3b_opcode opcode;
	lc3b_reg    sr1_idx;
	lc3b_reg    sr2_idx;
	lc3b_word   sr1_val;
	lc3b_word   sr2_val;
	lc3b_cw     cw;

	assign opcode  = if_ir[15:12];
	assign sr1_idx = if_ir[8:6];  // Also BaseR for LDR/STR
	assign sr2_idx = (opcode == op_str) ? if_ir[11:9] : if_ir[2:0];

	// Write-through so a decode in the WB cycle sees the new value
	assign sr1_val = (wb_load && wb_dest == sr1_idx) ? wb_data : regs[sr1_idx];
	assign sr2_val = (wb_load && wb_dest == sr2_idx) ? wb_data : regs[sr2_idx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 8; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_load) begin
			regs[wb_dest] <= wb_data;
		end
	end

	// Control word from the opcode
	always_comb begin
		cw = '0;
		case (opcode)
			op_add: begin
				cw[cw_load_regfile]           = 1'b1;
				cw[cw_imm]                    = if_ir[5];
				cw[cw_alu_msb:cw_alu_lsb]     = alu_add;
			end
			op_and: begin
				cw[cw_load_regfile]           = 1'b1;
				cw[cw_imm]                    = if_ir[5];
				cw[cw_alu_msb:cw_alu_lsb]     = alu_and;
			end
			op_not: begin
				cw[cw_load_regfile]           = 1'b1;
				cw[cw_alu_msb:cw_alu_lsb]     = alu_not;
			end
			op_ldr: begin
				cw[cw_load_regfile]           = 1'b1;
				cw[cw_mem_read]               = 1'b1;
				cw[cw_alu_msb:cw_alu_lsb]     = alu_add;  // Base + offset6
				cw[cw_wb_sel]                 = wb_mdr;
			end
			op_str: begin
				cw[cw_mem_write]              = 1'b1;
				cw[cw_alu_msb:cw_alu_lsb]     = alu_add;
			end
			op_br: begin
				cw[cw_branch]                 = |if_ir[11:9];  // nzp = 000 stays all zero
			end
			default: cw = '0;  // Unsupported opcodes act as NOPs
		endcase
	end

	// ID/EX register
	always_ff @(posedge clk) begin
		if (rst) begin
			id_ir  <= nop_word;
			id_pc  <= '0;
			id_cw  <= '0;
			id_sr1 <= '0;
			id_sr2 <= '0;
		end else begin
			id_ir  <= br_taken ? nop_word : if_ir;
			id_cw  <= br_taken ? '0 : cw;
			id_pc  <= if_pc;
			id_sr1 <= sr1_val;
			id_sr2 <= sr2_val;
		end
	end

endmodule : instruction_decode

// File: instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch import lc3b_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     br_taken,
	input  lc3b_word br_target,
	input  lc3b_word mem_rdata1,
	output lc3b_word mem_address1,
	output logic     mem_read1,
	output lc3b_word if_ir,
	output lc3b_word if_pc
);

	lc3b_word pc;
	lc3b_word pc_plus2;
	lc3b_word next_pc;

	assign pc_plus2     = pc + 16'd2;
	assign next_pc      = br_taken ? br_target : pc_plus2;  // Redirect wins over sequential
	assign mem_address1 = pc;
	assign mem_read1    = ~rst;  // Fetch every cycle once running

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else begin
			pc <= next_pc;
		end
	end

	// IF/ID register
	always_ff @(posedge clk) begin
		if (rst) begin
			if_ir <= nop_word;
			if_pc <= '0;
		end else begin
			if_ir <= br_taken ? nop_word : mem_rdata1;  // Squash wrong-path fetch
			if_pc <= pc_plus2;
		end
	end

endmodule : instruction_fetch

// File: lc3b_pkg.sv
package lc3b_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;
	typedef logic [3:0]  lc3b_opcode;
	typedef logic [2:0]  lc3b_nzp;    // Negative, zero, positive
	typedef logic [15:0] lc3b_cw;     // Control word carried down the pipe

	localparam lc3b_opcode op_br  = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;
	localparam lc3b_opcode op_not = 4'b1001;

	// BR with nzp = 000, never taken
	localparam lc3b_word nop_word = 16'h0000;

	typedef enum logic [1:0] {
		alu_add  = 2'd0,
		alu_and  = 2'd1,
		alu_not  = 2'd2,
		alu_pass = 2'd3
	} alu_op_t;

	typedef enum logic {
		wb_alu = 1'b0,
		wb_mdr = 1'b1
	} wb_sel_t;

	// Control word bit layout
	localparam int cw_load_regfile = 0;
	localparam int cw_mem_read     = 1;
	localparam int cw_mem_write    = 2;
	localparam int cw_branch       = 3;
	localparam int cw_imm          = 4;  // Second operand is imm5
	localparam int cw_alu_lsb      = 5;
	localparam int cw_alu_msb      = 6;
	localparam int cw_wb_sel       = 7;  // Holds a wb_sel_t

endpackage : lc3b_pkg

// File: memory_module.sv
`timescale 1ns/1ps

module memory_module import lc3b_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  lc3b_word ex_ir,
	input  lc3b_cw   ex_cw,
	input  lc3b_word ex_alu,
	input  lc3b_word ex_sr2,
	input  lc3b_word mem_rdata2,
	output lc3b_word mem_address2,
	output lc3b_word mem_wdata2,
	output logic     mem_read2,
	output logic     mem_write2,
	output logic     wb_load,
	output lc3b_reg  wb_dest,
	output lc3b_word wb_data,
	output lc3b_nzp  nzp
);

	wb_sel_t  wb_sel;
	lc3b_word wb_value;

	// Data port driven straight from EX/MEM
	assign mem_address2 = ex_alu;
	assign mem_wdata2   = ex_sr2;
	assign mem_read2    = ex_cw[cw_mem_read];
	assign mem_write2   = ex_cw[cw_mem_write];

	assign wb_sel   = wb_sel_t'(ex_cw[cw_wb_sel]);
	assign wb_value = (wb_sel == wb_mdr) ? mem_rdata2 : ex_alu;

	// MEM/WB register
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_load <= 1'b0;
			wb_dest <= '0;
			wb_data <= '0;
		end else begin
			wb_load <= ex_cw[cw_load_regfile];
			wb_dest <= ex_ir[11:9];  // DR field
			wb_data <= wb_value;
		end
	end

	// Condition codes follow the value written back
	always_ff @(posedge clk) begin
		if (rst)
			nzp <= 3'b010;
		else if (wb_load)
			nzp <= {wb_data[15], wb_data == '0, !wb_data[15] && wb_data != '0};
	end

endmodule : memory_module

// File: tb.f
lc3b_pkg.sv
instruction_fetch.sv
instruction_decode.sv
execution_module.sv
memory_module.sv
cpu_datapath.sv
cpu_datapath_chk.sv
tb_cpu_datapath.sv

// File: tb_cpu_datapath.sv
`timescale 1ns/1ps

module tb_cpu_datapath import lc3b_pkg::*; ();

	localparam int n_stores      = 12;
	localparam int store_timeout = 64;  // Cycles allowed between two stores

	logic        clk;
	logic        rst;
	lc3b_word    mem_rdata1;
	lc3b_word    mem_rdata2;
	lc3b_word    mem_address1;
	lc3b_word    mem_address2;
	lc3b_word    mem_wdata2;
	logic        mem_read1;
	logic        mem_read2;
	logic        mem_write2;
	lc3b_word    imem [64];
	lc3b_word    dmem [32768];
	lc3b_word    lfsr_data [8];
	logic [31:0] lfsr_state;
	lc3b_word    exp_addr [n_stores];
	int          exp_src [n_stores];  // LFSR word index, or -1 for a fixed value
	lc3b_word    exp_val [n_stores];
	lc3b_word    expected;
	int          data_errors = 0;
	int          addr_errors = 0;
	int          other_errors = 0;
	int          store_count = 0;
	bit          seen;

	cpu_datapath DUT (
		.clk          (clk),
		.rst          (rst),
		.mem_rdata1   (mem_rdata1),
		.mem_rdata2   (mem_rdata2),
		.mem_address1 (mem_address1),
		.mem_read1    (mem_read1),
		.mem_address2 (mem_address2),
		.mem_wdata2   (mem_wdata2),
		.mem_read2    (mem_read2),
		.mem_write2   (mem_write2)
	);

	bind cpu_datapath cpu_datapath_chk port_chk (
		.clk        (clk),
		.rst        (rst),
		.mem_read1  (mem_read1),
		.mem_read2  (mem_read2),
		.mem_write2 (mem_write2)
	);

	always #50 clk = ~clk;

	// Both memories answer in the same cycle
	assign mem_rdata1 = (mem_address1 < 16'h0080) ? imem[mem_address1[6:1]] : nop_word;
	assign mem_rdata2 = mem_read2 ? dmem[mem_address2[15:1]] : 'x;  // No data unless reading

	always @(posedge clk) begin
		if (mem_write2)
			dmem[mem_address2[15:1]] <= mem_wdata2;
	end

	always @(negedge clk) begin
		if (!rst && mem_write2)
			store_count++;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic next_lfsr_word(output lc3b_word w);
		for (int b = 0; b < 16; b++) begin
			w[b] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic put_instr(input lc3b_word addr, input lc3b_word word);
		imem[addr[6:1]] = word;
	endtask

	task automatic set_store(input int i, input lc3b_word addr, input int src, input lc3b_word val);
		exp_addr[i] = addr;
		exp_src[i]  = src;
		exp_val[i]  = val;
	endtask

	task automatic check_word(input lc3b_word got, input lc3b_word exp, input string what);
		if (got !== exp) begin
			data_errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input lc3b_word got, input lc3b_word exp, input string what);
		if (got !== exp) begin
			addr_errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic wait_for_store(input int limit, output bit found);
		int cycles;
		found  = 1'b0;
		cycles = 0;
		while (!found && cycles < limit) begin
			@(negedge clk);
			cycles++;
			if (mem_write2)
				found = 1'b1;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		for (int a = 0; a < 32768; a++)
			dmem[a] = lc3b_word'(a << 1) ^ 16'hc35a;  // Byte address pattern
		lfsr_state = 32'h87f1;
		for (int i = 0; i < 8; i++) begin
			next_lfsr_word(lfsr_data[i]);
			dmem[16'h0080 + i] = lfsr_data[i];  // Byte address 0x0100 onward
		end
		for (int i = 0; i < 64; i++)
			imem[i] = nop_word;

		put_instr(16'h0000, 16'h1225);  // ADD R1, R0, #5
		put_instr(16'h0002, 16'h143d);  // ADD R2, R0, #-3
		put_instr(16'h0004, 16'h1e28);  // ADD R7, R0, #8
		put_instr(16'h0006, 16'h967f);  // NOT R3, R1
		put_instr(16'h0008, 16'h58ae);  // AND R4, R2, #14
		put_instr(16'h000a, 16'h1fc7);  // ADD R7, R7, R7
		put_instr(16'h000c, 16'h7210);  // STR R1, R0, #16
		put_instr(16'h000e, 16'h7611);  // STR R3, R0, #17
		put_instr(16'h0010, 16'h7812);  // STR R4, R0, #18
		put_instr(16'h0012, 16'h1fc7);  // ADD R7, R7, R7
		put_instr(16'h0014, 16'h5ac2);  // AND R5, R3, R2
		put_instr(16'h0016, 16'h1c44);  // ADD R6, R1, R4
		put_instr(16'h0018, 16'h1fc7);  // ADD R7, R7, R7
		put_instr(16'h001a, 16'h7a13);  // STR R5, R0, #19
		put_instr(16'h001c, 16'h7c14);  // STR R6, R0, #20
		put_instr(16'h001e, 16'h1fc7);  // ADD R7, R7, R7
		put_instr(16'h0024, 16'h1fc7);  // ADD R7, R7, R7 gives 0x0100
		put_instr(16'h002a, 16'h63c3);  // LDR R1, R7, #3
		put_instr(16'h002c, 16'h65c6);  // LDR R2, R7, #6
		put_instr(16'h002e, 16'h7e15);  // STR R7, R0, #21
		put_instr(16'h0030, 16'h1269);  // ADD R1, R1, #9
		put_instr(16'h0032, 16'h14b9);  // ADD R2, R2, #-7
		put_instr(16'h0036, 16'h73c3);  // STR R1, R7, #3
		put_instr(16'h0038, 16'h75f9);  // STR R2, R7, #-7
		put_instr(16'h003a, 16'h5620);  // AND R3, R0, #0 sets z
		put_instr(16'h0040, 16'h0a02);  // BRnp, falls through
		put_instr(16'h0042, 16'h7816);  // STR R4, R0, #22
		put_instr(16'h0044, 16'h9b3f);  // NOT R5, R4 sets n
		put_instr(16'h004a, 16'h0601);  // BRzp, falls through
		put_instr(16'h004c, 16'h7a17);  // STR R5, R0, #23
		put_instr(16'h004e, 16'h0805);  // BRn to 0x005a, taken
		put_instr(16'h0050, 16'h7218);  // STR in first squashed slot
		put_instr(16'h0052, 16'h7419);  // STR in second squashed slot
		put_instr(16'h0054, 16'h761a);  // STR at a skipped address
		put_instr(16'h005a, 16'h7c1b);  // STR R6, R0, #27
		put_instr(16'h005c, 16'h7e1c);  // STR R7, R0, #28
		put_instr(16'h005e, 16'h0fff);  // BRnzp to itself

		set_store(0, 16'h0020, -1, 16'd5);
		set_store(1, 16'h0022, -1, ~16'd5);
		set_store(2, 16'h0024, -1, 16'hfffd & 16'd14);
		set_store(3, 16'h0026, -1, (~16'd5) & 16'hfffd);
		set_store(4, 16'h0028, -1, 16'd5 + (16'hfffd & 16'd14));
		set_store(5, 16'h002a, -1, 16'd8 << 5);
		set_store(6, 16'h0106, 3, 16'd9);
		set_store(7, 16'h00f2, 6, -16'sd7);
		set_store(8, 16'h002c, -1, 16'hfffd & 16'd14);
		set_store(9, 16'h002e, -1, ~(16'hfffd & 16'd14));
		set_store(10, 16'h0036, -1, 16'd5 + (16'hfffd & 16'd14));
		set_store(11, 16'h0038, -1, 16'd8 << 5);

		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		@(negedge clk);
		check_addr(mem_address1, 16'h0000, "first fetch address");

		for (int i = 0; i < n_stores; i++) begin
			wait_for_store(store_timeout, seen);
			if (!seen) begin
				other_errors++;
				$display("Timed out waiting for store %0d on the data port", i);
				break;
			end
			expected = (exp_src[i] < 0) ? exp_val[i] : lfsr_data[exp_src[i]] + exp_val[i];
			check_addr(mem_address2, exp_addr[i], $sformatf("store %0d address", i));
			check_word(mem_wdata2, expected, $sformatf("store %0d data", i));
		end

		repeat (32) @(negedge clk);  // Window for stray stores after the last one
		if (store_count != n_stores) begin
			other_errors++;
			$display("Saw %0d stores on the data port, expected %0d", store_count, n_stores);
		end

		$display("Errors: data %0d, address %0d, other %0d, assertion %0d",
			data_errors, addr_errors, other_errors, DUT.port_chk.fails);
		if (data_errors + addr_errors + other_errors + DUT.port_chk.fails == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule : tb_cpu_datapath
